// ==== logic/cache_pkg.sv ====
// cache package with the fixed line geometry and the shared packed types
package cache_pkg;

  // word and beat widths on the two sides of the cache
  localparam int word_bits = 32;
  localparam int beat_bits = 64;

  // eight words per line, moved as four beats
  localparam int column_count = 8;
  localparam int beats_per_line = 4;
  localparam int column_bits = 3;

  // byte offset within a word, not used for lookup
  localparam int offset_bits = 2;

  // whole line address, kept as the tag
  localparam int line_tag_bits = word_bits - column_bits - offset_bits;

  typedef logic [word_bits-1:0] word_t;

  // low half is the even column, high half the odd column
  typedef logic [beat_bits-1:0] beat_t;

  typedef logic [line_tag_bits-1:0] line_tag_t;

  typedef struct packed {
    logic      dirty;
    logic      valid;
    line_tag_t tag;
  } tag_entry_t;

  // line address before the addressing-mode shift
  typedef struct packed {
    logic      write;
    logic      en;
    line_tag_t line;
  } burst_cmd_t;

  typedef struct packed {
    logic [3:0] mask;
    word_t      data;
  } col_write_t;

endpackage

// ==== logic/bram_sdp.sv ====
// synchronous single-address RAM with registered write-first read and lane write mask
module bram_sdp #(
  parameter type entry_t = logic [31:0],
  parameter int addr_bits = 8,
  parameter int lanes = 4
) (
  input  logic                 clk,
  input  logic [lanes-1:0]     we,
  input  logic [addr_bits-1:0] addr,
  input  entry_t               wdata,
  output entry_t               rdata
);

  localparam int lane_bits = $bits(entry_t) / lanes;

  typedef logic [lanes-1:0][lane_bits-1:0] lane_vec_t;

  lane_vec_t mem [2**addr_bits];
  lane_vec_t wvec;
  lane_vec_t rvec;

  assign wvec = lane_vec_t'(wdata);

  // a written lane shows up on the read port in the next cycle
  always_ff @(posedge clk) begin
    for (int l = 0; l < lanes; l++) begin
      if (we[l]) begin
        mem[addr][l] <= wvec[l];
        rvec[l] <= wvec[l];
      end else begin
        rvec[l] <= mem[addr][l];
      end
    end
  end

  assign rdata = entry_t'(rvec);

endmodule

// ==== logic/cache_lookup.sv ====
// cache address decode and tag compare against the stored line entry
module cache_lookup #(
  parameter int line_index_bits = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              busy,
  input  cache_pkg::word_t                  address,
  input  cache_pkg::tag_entry_t             stored,
  output logic [line_index_bits-1:0]        line_ix,
  output logic [cache_pkg::column_bits-1:0] column_ix,
  output logic                              hit,
  output logic                              dirty,
  output cache_pkg::line_tag_t              req_line,
  output cache_pkg::line_tag_t              victim_line
);

  import cache_pkg::*;

  localparam int line_lsb = offset_bits + column_bits;

  // |line address                   |col|00|
  //           |line index           |
  assign column_ix = address[offset_bits +: column_bits];
  assign line_ix = address[line_lsb +: line_index_bits];
  assign req_line = address[word_bits-1:line_lsb];

  // the tag holds the full line address, so an entry read for
  // another line index can never match the request
  assign hit = stored.valid && (stored.tag == req_line);

  // only a valid line can need a write-back
  assign dirty = stored.valid && stored.dirty;

  // line address of the resident line, written back on eviction
  assign victim_line = stored.tag;

  // requester must hold the address while busy and one cycle after
  a_address_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    busy |=> $stable(address)
  ) else $error("address changed while cache busy");

endmodule

// ==== logic/line_store.sv ====
// cache line storage with eight word RAMs, the tag RAM and the tag clear sweep
module line_store #(
  parameter int line_index_bits = 8
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [line_index_bits-1:0]                             line_ix,
  input  logic [cache_pkg::column_bits-1:0]                      column_ix,
  input  cache_pkg::col_write_t                                  host_wr,
  input  logic                                                   hit,
  input  logic                                                   fill_active,
  input  logic [cache_pkg::column_count-1:0]                     fill_mask,
  input  cache_pkg::beat_t                                       fill_beat,
  input  logic                                                   tag_commit,
  input  cache_pkg::tag_entry_t                                  tag_new,
  output logic                                                   sweeping,
  output cache_pkg::tag_entry_t                                  stored,
  output cache_pkg::word_t [cache_pkg::column_count-1:0]         words,
  output cache_pkg::word_t                                       data_out
);

  import cache_pkg::*;

  logic [line_index_bits:0]   sweep_cnt;
  logic                       sweep_wr;
  logic                       host_write;
  logic                       tag_we;
  logic [line_index_bits-1:0] tag_addr;
  tag_entry_t                 tag_wdata;

  // hit-write from the requester, never during the reset sweep
  assign host_write = hit && (host_wr.mask != 4'b0) && !sweeping;

  for (genvar c = 0; c < column_count; c++) begin : g_col
    localparam int half = c % 2;

    logic [3:0] we;
    word_t      wdata;

    always_comb begin
      we = 4'b0;
      wdata = host_wr.data;
      if (fill_active) begin
        we = {4{fill_mask[c]}};
        wdata = fill_beat[half*word_bits +: word_bits];
      end else if (host_write && (column_ix == column_bits'(c))) begin
        we = host_wr.mask;
      end
    end

    bram_sdp #(
      .entry_t  (word_t),
      .addr_bits(line_index_bits),
      .lanes    (4)
    ) u_word (
      .clk  (clk),
      .we   (we),
      .addr (line_ix),
      .wdata(wdata),
      .rdata(words[c])
    );
  end

  assign data_out = words[column_ix];

  // one extra sweep cycle reads back the entry for the held line index
  assign sweep_wr = sweeping && !sweep_cnt[line_index_bits];
  assign tag_addr = sweep_wr ? sweep_cnt[line_index_bits-1:0] : line_ix;

  always_comb begin
    tag_we = 1'b0;
    tag_wdata = tag_new;
    if (sweeping) begin
      tag_we = sweep_wr;
      tag_wdata = '0;
    end else if (tag_commit) begin
      tag_we = 1'b1;
    end else if (host_write) begin
      tag_we = 1'b1;
      tag_wdata = '{dirty: 1'b1, valid: 1'b1, tag: stored.tag};
    end
  end

  bram_sdp #(
    .entry_t  (tag_entry_t),
    .addr_bits(line_index_bits),
    .lanes    (1)
  ) u_tag (
    .clk  (clk),
    .we   (tag_we),
    .addr (tag_addr),
    .wdata(tag_wdata),
    .rdata(stored)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sweep_cnt <= '0;
      sweeping <= 1'b1;
    end else if (sweeping) begin
      if (sweep_cnt[line_index_bits]) begin
        sweeping <= 1'b0;
      end else begin
        sweep_cnt <= sweep_cnt + 1'b1;
      end
    end
  end

  // a host write only lands on a hit, which the burst path never produces
  a_write_paths_apart : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(host_write && (fill_active || tag_commit))
  ) else $error("host write collides with line fill");

endmodule

// ==== logic/burst_ctrl.sv ====
// miss sequencer for line eviction and fill over the burst RAM port
module burst_ctrl #(
  parameter int cmd_interval_cycles = 13
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           enable,
  input  logic [3:0]                                     write_enable,
  input  logic                                           hit,
  input  logic                                           dirty,
  input  logic                                           sweeping,
  input  cache_pkg::line_tag_t                           req_line,
  input  cache_pkg::line_tag_t                           victim_line,
  input  cache_pkg::word_t [cache_pkg::column_count-1:0] words,
  input  cache_pkg::beat_t                               br_rd_data,
  input  logic                                           br_rd_data_valid,
  output cache_pkg::burst_cmd_t                          cmd,
  output cache_pkg::beat_t                               wr_beat,
  output logic                                           fill_active,
  output logic [cache_pkg::column_count-1:0]             fill_mask,
  output cache_pkg::beat_t                               fill_beat,
  output logic                                           tag_commit,
  output cache_pkg::tag_entry_t                          tag_new,
  output logic                                           busy
);

  import cache_pkg::*;

  localparam int cnt_bits = $clog2(cmd_interval_cycles + 1);
  localparam int beat_ix_bits = $clog2(beats_per_line);

  typedef enum logic [2:0] {
    st_idle,
    st_evict,
    st_wait_gap,
    st_read_wait,
    st_fill,
    st_commit,
    st_finish
  } state_t;

  state_t                  state;
  logic [cnt_bits-1:0]     cmd_cnt;
  logic [beat_ix_bits-1:0] beat_ix;
  logic                    miss;
  logic                    miss_q;
  logic                    last_beat;

  assign miss = enable && !hit && !sweeping;
  assign last_beat = beat_ix == beat_ix_bits'(beats_per_line - 1);

  // busy falls in the finish cycle when the new tag reads back as a hit
  assign busy = sweeping || (state != st_idle && state != st_finish) || (enable && !hit);

  // fill beats go straight from the RAM bus into the column pair
  assign fill_active = br_rd_data_valid && (state == st_read_wait || state == st_fill);
  assign fill_beat = br_rd_data;

  always_comb begin
    fill_mask = '0;
    if (fill_active) begin
      fill_mask[{beat_ix, 1'b0} +: 2] = 2'b11;
    end
  end

  assign tag_commit = state == st_commit;
  assign tag_new = '{dirty: 1'b0, valid: 1'b1, tag: req_line};

  // beat_ix is zero in idle so beat 0 is ready when the write command goes out
  always_ff @(posedge clk) begin
    if (state == st_idle || state == st_evict) begin
      wr_beat <= {words[{beat_ix, 1'b1}], words[{beat_ix, 1'b0}]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      cmd <= '0;
      cmd_cnt <= '0;
      beat_ix <= '0;
      miss_q <= 1'b0;
    end else begin
      // command enable is a single-cycle pulse
      cmd.en <= 1'b0;
      if (cmd_cnt != '0) begin
        cmd_cnt <= cmd_cnt - 1'b1;
      end
      // a miss seen twice in a row is checked against the held address
      miss_q <= miss && (state == st_idle);

      case (state)
        st_idle: begin
          if (miss && miss_q && cmd_cnt == '0) begin
            cmd_cnt <= cnt_bits'(cmd_interval_cycles);
            if (dirty) begin
              cmd <= '{write: 1'b1, en: 1'b1, line: victim_line};
              beat_ix <= beat_ix + 1'b1;
              state <= st_evict;
            end else begin
              cmd <= '{write: 1'b0, en: 1'b1, line: req_line};
              state <= st_read_wait;
            end
          end
        end

        st_evict: begin
          // beats 1 to 3 of the write-back
          beat_ix <= beat_ix + 1'b1;
          if (last_beat) begin
            state <= st_wait_gap;
          end
        end

        st_wait_gap: begin
          if (cmd_cnt == '0) begin
            cmd_cnt <= cnt_bits'(cmd_interval_cycles);
            cmd <= '{write: 1'b0, en: 1'b1, line: req_line};
            state <= st_read_wait;
          end
        end

        st_read_wait: begin
          if (br_rd_data_valid) begin
            beat_ix <= beat_ix + 1'b1;
            state <= st_fill;
          end
        end

        st_fill: begin
          // remaining beats arrive back to back
          beat_ix <= beat_ix + 1'b1;
          if (last_beat) begin
            state <= st_commit;
          end
        end

        st_commit: begin
          state <= st_finish;
        end

        st_finish: begin
          state <= st_idle;
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // no two command pulses closer together than the interval allows
  for (genvar k = 1; k <= cmd_interval_cycles; k++) begin : g_cmd_gap
    a_cmd_spacing : assert property (
      @(posedge clk) disable iff (!rst_n)
      cmd.en |-> !$past(cmd.en, k)
    ) else $error("burst command issued inside the command interval");
  end

  a_wr_mask_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    busy |=> $stable(write_enable)
  ) else $error("write enable changed while cache busy");

endmodule

// ==== logic/cache_top.sv ====
// direct-mapped write-back cache top between a 32-bit requester and a burst RAM
module cache_top #(
  parameter int line_index_bits = 8,
  parameter int ram_addr_bits = 21,
  parameter int cmd_interval_cycles = 13,
  parameter int ram_addressing_mode = 0
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     enable,
  input  cache_pkg::word_t         address,
  input  logic [3:0]               write_enable,
  input  cache_pkg::word_t         data_in,
  output cache_pkg::word_t         data_out,
  output logic                     data_ready,
  output logic                     busy,
  output logic                     br_cmd,
  output logic                     br_cmd_en,
  output logic [ram_addr_bits-1:0] br_addr,
  output cache_pkg::beat_t         br_wr_data,
  output logic [7:0]               br_data_mask,
  input  cache_pkg::beat_t         br_rd_data,
  input  logic                     br_rd_data_valid
);

  import cache_pkg::*;

  logic [line_index_bits-1:0]   line_ix;
  logic [column_bits-1:0]       column_ix;
  logic                         hit;
  logic                         dirty;
  logic                         sweeping;
  line_tag_t                    req_line;
  line_tag_t                    victim_line;
  tag_entry_t                   stored;
  tag_entry_t                   tag_new;
  logic                         tag_commit;
  logic                         fill_active;
  logic [column_count-1:0]      fill_mask;
  beat_t                        fill_beat;
  word_t [column_count-1:0]     words;
  col_write_t                   host_wr;
  burst_cmd_t                   cmd;
  word_t                        cmd_byte_addr;

  assign host_wr = '{mask: enable ? write_enable : 4'b0, data: data_in};

  // reads only, a write is done when busy is low
  assign data_ready = enable && hit && (write_enable == 4'b0);

  // byte address of the line, then scaled to the RAM word size
  assign cmd_byte_addr = {cmd.line, {(column_bits + offset_bits){1'b0}}};
  assign br_addr = ram_addr_bits'(cmd_byte_addr >> ram_addressing_mode);
  assign br_cmd = cmd.write;
  assign br_cmd_en = cmd.en;
  // whole lines only
  assign br_data_mask = '0;

  cache_lookup #(.line_index_bits(line_index_bits)) u_lookup (
    .clk(clk), .rst_n(rst_n), .busy(busy), .address(address), .stored(stored),
    .line_ix(line_ix), .column_ix(column_ix), .hit(hit), .dirty(dirty),
    .req_line(req_line), .victim_line(victim_line)
  );

  line_store #(.line_index_bits(line_index_bits)) u_store (
    .clk(clk), .rst_n(rst_n), .line_ix(line_ix), .column_ix(column_ix),
    .host_wr(host_wr), .hit(hit), .fill_active(fill_active), .fill_mask(fill_mask),
    .fill_beat(fill_beat), .tag_commit(tag_commit), .tag_new(tag_new),
    .sweeping(sweeping), .stored(stored), .words(words), .data_out(data_out)
  );

  burst_ctrl #(.cmd_interval_cycles(cmd_interval_cycles)) u_burst (
    .clk(clk), .rst_n(rst_n), .enable(enable), .write_enable(write_enable),
    .hit(hit), .dirty(dirty), .sweeping(sweeping), .req_line(req_line),
    .victim_line(victim_line), .words(words), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid), .cmd(cmd), .wr_beat(br_wr_data),
    .fill_active(fill_active), .fill_mask(fill_mask), .fill_beat(fill_beat),
    .tag_commit(tag_commit), .tag_new(tag_new), .busy(busy)
  );

endmodule

// ==== verif/burst_ram_model.sv ====
// behavioral burst RAM with random read latency and a command spacing check
module burst_ram_model #(
  parameter int addr_bits = 21,
  parameter int min_cmd_gap = 14
) (
  input  logic                 clk,
  input  logic                 br_cmd,
  input  logic                 br_cmd_en,
  input  logic [addr_bits-1:0] br_addr,
  input  cache_pkg::beat_t     br_wr_data,
  input  logic [7:0]           br_data_mask,
  output cache_pkg::beat_t     br_rd_data,
  output logic                 br_rd_data_valid,
  output int                   violations
);
  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int word_count = 2 ** (addr_bits - 2);

  logic [31:0] mem [word_count];
  logic [31:0] rnd;
  int          cycle;
  int          last_cmd;
  int          rd_wait;
  int          rd_beat;
  int          rd_word;
  int          wr_left;
  int          wr_word;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // low half of a beat is the even word
  task automatic store_beat();
    mem[wr_word] = br_wr_data[31:0];
    mem[wr_word + 1] = br_wr_data[63:32];
    wr_word += 2;
  endtask

  initial begin
    // every word starts as its own byte address with the top nibble set to A
    for (int w = 0; w < word_count; w++) begin
      mem[w] = {4'hA, 28'(w * 4)};
    end
    rnd = 32'd66335;
    cycle = 0;
    last_cmd = -min_cmd_gap;
    rd_wait = 0;
    rd_beat = beats_per_line;
    rd_word = 0;
    wr_left = 0;
    wr_word = 0;
    violations = 0;
    br_rd_data = '0;
    br_rd_data_valid = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      br_rd_data_valid = 1'b0;
      if (rd_wait > 0) begin
        rd_wait--;
      end else if (rd_beat < beats_per_line) begin
        br_rd_data = {mem[rd_word + 2 * rd_beat + 1], mem[rd_word + 2 * rd_beat]};
        br_rd_data_valid = 1'b1;
        rd_beat++;
      end
      @(negedge clk);
      cycle++;
      assert (br_data_mask == 8'h00) else begin
        violations++;
        $display("[ERROR] ram data mask: expected %h, actual %h", 8'h00, br_data_mask);
      end
      if (wr_left > 0) begin
        store_beat();
        wr_left--;
      end
      if (br_cmd_en) begin
        assert (cycle - last_cmd >= min_cmd_gap) else begin
          violations++;
          $display("burst command came %0d cycles after the previous one, minimum is %0d",
                   cycle - last_cmd, min_cmd_gap);
        end
        last_cmd = cycle;
        wr_word = int'(br_addr[addr_bits-1:2]);
        if (br_cmd) begin
          store_beat();
          wr_left = beats_per_line - 1;
        end else begin
          rnd = xorshift32(rnd);
          // first beat 2 to 9 cycles after the command
          rd_wait = 1 + int'(rnd[2:0]);
          rd_word = int'(br_addr[addr_bits-1:2]);
          rd_beat = 0;
        end
      end
    end
  end

endmodule

// ==== verif/tb_cache_top.sv ====
// testbench for the burst cache, running the operations of the vectors file
module tb_cache_top;
  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int clk_period = 40;
  localparam int reset_cycles = 10;
  localparam int line_index_bits = 4;
  localparam int ram_addr_bits = 21;
  localparam int cmd_interval_cycles = 13;
  localparam int fields = 5;
  localparam int max_vectors = 64;
  // dirty miss with a full command interval and the longest read latency, rounded up
  localparam int worst_miss_cycles = 64;
  localparam int line_lsb = offset_bits + column_bits;

  logic                     clk;
  logic                     rst_n;
  logic                     enable;
  word_t                    address;
  logic [3:0]               write_enable;
  word_t                    data_in;
  word_t                    data_out;
  logic                     data_ready;
  logic                     busy;
  logic                     br_cmd;
  logic                     br_cmd_en;
  logic [ram_addr_bits-1:0] br_addr;
  beat_t                    br_wr_data;
  logic [7:0]               br_data_mask;
  beat_t                    br_rd_data;
  logic                     br_rd_data_valid;
  int                       ram_violations;

  logic [31:0] vec_words [max_vectors * fields];
  int          vec_count;
  int          errors;
  int          checks;
  int          current_op;
  bit          loaded;
  bit          prev_valid;
  line_tag_t   prev_line;
  bit          resident_valid [2 ** line_index_bits];
  line_tag_t   resident_line [2 ** line_index_bits];

  always #(clk_period / 2) clk = ~clk;

  cache_top #(
    .line_index_bits    (line_index_bits),
    .ram_addr_bits      (ram_addr_bits),
    .cmd_interval_cycles(cmd_interval_cycles),
    .ram_addressing_mode(0)
  ) DUT (
    .clk(clk), .rst_n(rst_n), .enable(enable), .address(address),
    .write_enable(write_enable), .data_in(data_in), .data_out(data_out),
    .data_ready(data_ready), .busy(busy), .br_cmd(br_cmd), .br_cmd_en(br_cmd_en),
    .br_addr(br_addr), .br_wr_data(br_wr_data), .br_data_mask(br_data_mask),
    .br_rd_data(br_rd_data), .br_rd_data_valid(br_rd_data_valid)
  );

  burst_ram_model #(.addr_bits(ram_addr_bits), .min_cmd_gap(cmd_interval_cycles + 1)) u_ram (
    .clk(clk), .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_wr_data(br_wr_data), .br_data_mask(br_data_mask), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid), .violations(ram_violations)
  );

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_true(bit cond, string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic run_op(int k);
    logic [31:0] kind;
    logic [31:0] addr;
    logic [31:0] mask;
    logic [31:0] data;
    logic [31:0] expected;
    line_tag_t   line;
    int          idx;
    bit          exp_hit;
    bit          same_line;
    bit          first;
    bit          done;
    bit          saw_busy;
    string       name;
    kind = vec_words[k * fields];
    addr = vec_words[k * fields + 1];
    mask = vec_words[k * fields + 2];
    data = vec_words[k * fields + 3];
    expected = vec_words[k * fields + 4];
    line = addr[word_bits-1:line_lsb];
    idx = int'(line[line_index_bits-1:0]);
    // direct mapped, so a hit needs the same full line address at this index
    exp_hit = resident_valid[idx] && (resident_line[idx] == line);
    same_line = prev_valid && (prev_line == line);
    name = $sformatf("op %0d %s %h", k, (kind == 1) ? "write" : "read", addr);
    current_op = k;
    @(posedge clk);
    #2;
    enable = 1'b1;
    address = addr;
    write_enable = mask[3:0];
    data_in = data;
    first = 1'b1;
    done = 1'b0;
    saw_busy = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (first && !exp_hit) begin
        check_true(busy, $sformatf("%s missed but busy stayed low in its first cycle", name));
      end
      saw_busy = saw_busy || busy;
      if (kind == 1) begin
        check_value({name, " data_ready"}, 32'd0, 32'(data_ready));
        done = !busy;
      end else if (data_ready) begin
        check_value(name, expected, data_out);
        check_value({name, " busy"}, 32'd0, 32'(busy));
        done = 1'b1;
      end
      first = 1'b0;
    end
    @(posedge clk);
    #2;
    enable = 1'b0;
    write_enable = 4'b0;
    if (exp_hit && same_line) begin
      check_true(!saw_busy, $sformatf("%s hit the line just used but busy rose", name));
    end
    resident_valid[idx] = 1'b1;
    resident_line[idx] = line;
    prev_valid = 1'b1;
    prev_line = line;
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    write_enable = 4'b0;
    data_in = '0;
    errors = 0;
    checks = 0;
    current_op = -1;
    prev_valid = 1'b0;
    prev_line = '0;
    for (int i = 0; i < 2 ** line_index_bits; i++) begin
      resident_valid[i] = 1'b0;
      resident_line[i] = '0;
    end
    // unused entries keep an invalid kind and end the list
    for (int i = 0; i < max_vectors * fields; i++) begin
      vec_words[i] = '1;
    end
    $readmemh("verif/cache_vectors.txt", vec_words);
    vec_count = 0;
    while (vec_count < max_vectors && vec_words[vec_count * fields] <= 32'd1) begin
      vec_count++;
    end
    loaded = 1'b1;
    repeat (reset_cycles - 1) @(posedge clk);
    @(negedge clk);
    check_value("data_ready in reset", 32'd0, 32'(data_ready));
    check_value("br_cmd_en in reset", 32'd0, 32'(br_cmd_en));
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    // tag clear sweep keeps busy high
    do begin
      @(negedge clk);
    end while (busy);
    check_value("data_ready after reset", 32'd0, 32'(data_ready));
    check_value("br_cmd_en after reset", 32'd0, 32'(br_cmd_en));
    for (int k = 0; k < vec_count; k++) begin
      run_op(k);
    end
    repeat (4) @(posedge clk);
    $display("summary: %0d checks, %0d testbench errors, %0d burst RAM violations",
             checks, errors, ram_violations);
    if (errors == 0 && ram_violations == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (loaded);
    limit = (vec_count * worst_miss_cycles + reset_cycles + 2 ** line_index_bits + 8) * clk_period;
    #(limit);
    $display("watchdog expired at %0t ns with operation %0d unfinished", $time, current_op);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== cache_burst.f ====
logic/cache_pkg.sv
logic/bram_sdp.sv
logic/cache_lookup.sv
logic/line_store.sv
logic/burst_ctrl.sv
logic/cache_top.sv
verif/burst_ram_model.sv
verif/tb_cache_top.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_top -f cache_burst.f
	./obj_dir/Vtb_cache_top | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation reported failures"; exit 1; fi
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== verif/cache_vectors.txt ====
// kind (0 read, 1 write), byte address, write mask, write data, expected read value
// all fields hex, the expected value of a write is unused
0 00001040 0 00000000 A0001040
0 00001044 0 00000000 A0001044
0 0000105C 0 00000000 A000105C
0 00001048 0 00000000 A0001048
1 00001048 3 12345678 00000000
0 00001048 0 00000000 A0005678
0 00001050 0 00000000 A0001050
1 0000104C 8 BB000000 00000000
0 0000104C 0 00000000 BB00104C
0 00001244 0 00000000 A0001244
0 0000125C 0 00000000 A000125C
0 00001048 0 00000000 A0005678
0 0000104C 0 00000000 BB00104C
0 00001040 0 00000000 A0001040
1 000400A4 5 11223344 00000000
0 000400A4 0 00000000 A0220044
0 000400B8 0 00000000 A00400B8
0 000002A0 0 00000000 A00002A0
0 000400A4 0 00000000 A0220044
1 00001054 F CAFEF00D 00000000
0 00001054 0 00000000 CAFEF00D
